// ==== files.f ====
rtl/rtp_pkg.sv
rtl/rtp_engine_regmap.sv
rtl/rtp_frame_fsm.sv
rtl/rtp_pos_counter.sv
rtl/rtp_word_builder.sv
rtl/rtp_engine.sv
tests/tb_rtp_engine.sv

// ==== rtl/rtp_engine.sv ====
/* rtp video packet engine
   register map, frame state machine, position counter and word builder */

`timescale 1ns/1ps

module rtp_engine import rtp_pkg::*; #(
  parameter logic [31:0] VERSION    = 32'd1,
  parameter int          CREDIT_MAX = 8
) (
  input  logic      up_clk,
  input  logic      up_rstn,
  input  logic      up_wreq,
  input  rtp_addr_t up_waddr,
  input  rtp_word_t up_wdata,
  output logic      up_wack,
  input  logic      up_rreq,
  input  rtp_addr_t up_raddr,
  output rtp_word_t up_rdata,
  output logic      up_rack,
  output logic      tx_valid,
  output rtp_word_t tx_data,
  output logic      tx_sop,
  output logic      tx_eop,
  input  logic      tx_credit
);

  rtp_cfg_t cfg;
  rtp_pos_t pos;
  logic     frame_start;
  logic     busy;
  logic     advance;
  logic     phase;
  logic     frame_clear;

  // processor side configuration and control
  rtp_engine_regmap #(
    .VERSION(VERSION)
  ) u_regmap (
    .up_clk(up_clk),
    .up_rstn(up_rstn),
    .up_wreq(up_wreq),
    .up_waddr(up_waddr),
    .up_wdata(up_wdata),
    .up_wack(up_wack),
    .up_rreq(up_rreq),
    .up_raddr(up_raddr),
    .up_rdata(up_rdata),
    .up_rack(up_rack),
    .busy(busy),
    .cfg(cfg),
    .frame_start(frame_start)
  );

  // frame sequencing and flow control toward the sink
  rtp_frame_fsm #(
    .CREDIT_MAX(CREDIT_MAX)
  ) u_fsm (
    .up_clk(up_clk),
    .up_rstn(up_rstn),
    .frame_start(frame_start),
    .cfg(cfg),
    .pos(pos),
    .tx_credit(tx_credit),
    .advance(advance),
    .phase(phase),
    .frame_clear(frame_clear),
    .busy(busy)
  );

  rtp_pos_counter u_counter (
    .up_clk(up_clk),
    .up_rstn(up_rstn),
    .advance(advance),
    .phase(phase),
    .frame_clear(frame_clear),
    .cfg(cfg),
    .pos(pos)
  );

  // registered stream output
  rtp_word_builder u_builder (
    .up_clk(up_clk),
    .up_rstn(up_rstn),
    .advance(advance),
    .phase(phase),
    .cfg(cfg),
    .pos(pos),
    .tx_valid(tx_valid),
    .tx_data(tx_data),
    .tx_sop(tx_sop),
    .tx_eop(tx_eop)
  );

endmodule

// ==== rtl/rtp_engine_regmap.sv ====
/* rtp engine register map
   holds the packet configuration and issues the frame start pulse */

`timescale 1ns/1ps

module rtp_engine_regmap import rtp_pkg::*; #(
  parameter logic [31:0] VERSION = 32'd1
) (
  input  logic      up_clk,
  input  logic      up_rstn,
  input  logic      up_wreq,
  input  rtp_addr_t up_waddr,
  input  rtp_word_t up_wdata,
  output logic      up_wack,
  input  logic      up_rreq,
  input  rtp_addr_t up_raddr,
  output rtp_word_t up_rdata,
  output logic      up_rack,
  input  logic      busy,
  output rtp_cfg_t  cfg,
  output logic      frame_start
);

  // **************************************************
  // write side
  // **************************************************

  // every write is acknowledged one cycle later, mapped or not
  // each field keeps only as many data bits as it is wide
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack     <= 1'b0;
      frame_start <= 1'b0;
      cfg         <= '0;
    end else begin
      up_wack     <= up_wreq;
      // the start bit is self clearing, so this is a single cycle pulse
      frame_start <= up_wreq && (up_waddr == 14'hf) && up_wdata[0];
      if (up_wreq) begin
        case (up_waddr)
          14'h1: cfg.dest_addr_hb <= up_wdata;
          14'h2: cfg.dest_addr_lb <= up_wdata[15:0];
          14'h3: cfg.source_addr_hb <= up_wdata;
          14'h4: cfg.source_addr_lb <= up_wdata[15:0];
          14'h5: cfg.src_ip_addr <= up_wdata;
          14'h6: cfg.dest_ip_addr <= up_wdata;
          14'h7: cfg.ip_qos <= up_wdata[7:0];
          // both udp ports share one register, source port on top
          14'h8: begin
            cfg.udp_src_port  <= up_wdata[31:16];
            cfg.udp_dest_port <= up_wdata[15:0];
          end
          14'h9: cfg.num_lines <= up_wdata[11:0];
          14'ha: cfg.num_px_p_line <= up_wdata[11:0];
          14'hb: cfg.custom_timestamp <= up_wdata[0];
          14'hc: cfg.custom_timestamp_96b <= up_wdata[0];
          14'hd: cfg.timestamp_s_eof <= up_wdata[0];
          14'he: cfg.timestamp_network_pwm_genval <= up_wdata[0];
          default: ;
        endcase
      end
    end
  end

  // **************************************************
  // read side
  // **************************************************

  // the ack follows the request by exactly one cycle
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rack <= 1'b0;
    end else begin
      up_rack <= up_rreq;
    end
  end

  // read data is captured together with the ack, zero outside 0x0 to 0xf
  always_ff @(posedge up_clk) begin
    if (up_rreq) begin
      case (up_raddr)
        14'h0: up_rdata <= VERSION;
        14'h1: up_rdata <= cfg.dest_addr_hb;
        14'h2: up_rdata <= {16'd0, cfg.dest_addr_lb};
        14'h3: up_rdata <= cfg.source_addr_hb;
        14'h4: up_rdata <= {16'd0, cfg.source_addr_lb};
        14'h5: up_rdata <= cfg.src_ip_addr;
        14'h6: up_rdata <= cfg.dest_ip_addr;
        14'h7: up_rdata <= {24'd0, cfg.ip_qos};
        14'h8: up_rdata <= {cfg.udp_src_port, cfg.udp_dest_port};
        14'h9: up_rdata <= {20'd0, cfg.num_lines};
        14'ha: up_rdata <= {20'd0, cfg.num_px_p_line};
        14'hb: up_rdata <= {31'd0, cfg.custom_timestamp};
        14'hc: up_rdata <= {31'd0, cfg.custom_timestamp_96b};
        14'hd: up_rdata <= {31'd0, cfg.timestamp_s_eof};
        14'he: up_rdata <= {31'd0, cfg.timestamp_network_pwm_genval};
        // control and status, bit 0 reads back the engine busy flag
        14'hf: up_rdata <= {31'd0, busy};
        default: up_rdata <= '0;
      endcase
    end
  end

  // a write ack never shows up without a write request the cycle before
  a_wack_follows_wreq: assert property (
    @(posedge up_clk) disable iff (!up_rstn) up_wack |-> $past(up_wreq)
  );

endmodule

// ==== rtl/rtp_frame_fsm.sv ====
/* rtp frame state machine
   walks each line through header and payload phases and tracks sink credits */

`timescale 1ns/1ps

module rtp_frame_fsm import rtp_pkg::*; #(
  parameter int CREDIT_MAX = 8
) (
  input  logic     up_clk,
  input  logic     up_rstn,
  input  logic     frame_start,
  input  rtp_cfg_t cfg,
  input  rtp_pos_t pos,
  input  logic     tx_credit,
  output logic     advance,
  output logic     phase,
  output logic     frame_clear,
  output logic     busy
);

  localparam int CW = $clog2(CREDIT_MAX + 1);

  rtp_state_e state;
  rtp_state_e state_next;
  logic [CW-1:0] credits;
  logic hdr_last;
  logic px_last;
  logic line_last;

  // **************************************************
  // credit accounting
  // **************************************************

  // a credit is taken when the word is issued, one cycle before tx_valid
  // the sink cannot return it earlier than that, so the count stays safe
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      credits <= CW'(CREDIT_MAX);
    end else begin
      case ({advance, tx_credit})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: ;
      endcase
    end
  end

  // **************************************************
  // state sequencing
  // **************************************************

  assign hdr_last  = (pos.hdr_idx == 3'(HDR_WORDS - 1));
  assign px_last   = (pos.px_idx == cfg.num_px_p_line - 12'd1);
  assign line_last = (pos.line_idx == cfg.num_lines - 12'd1);

  // words go out only in the two sending states and only with a credit left
  assign advance = ((state == st_header) || (state == st_payload)) && (credits != '0);
  // phase is high while pixel words are issued
  assign phase = (state == st_payload);
  // the frame end state rewinds the line and pixel indices
  assign frame_clear = (state == st_frame_end);
  assign busy = (state != st_idle);

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (frame_start) begin
          state_next = (cfg.num_lines == '0) ? st_frame_end : st_header;
        end
      end
      st_header: begin
        // a line without pixels ends right after header word 7
        if (advance && hdr_last) begin
          if (cfg.num_px_p_line != '0) begin
            state_next = st_payload;
          end else begin
            state_next = line_last ? st_frame_end : st_header;
          end
        end
      end
      st_payload: begin
        if (advance && px_last) begin
          state_next = line_last ? st_frame_end : st_header;
        end
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // the sink must never hand back more credits than it was given
  a_credit_bound: assert property (
    @(posedge up_clk) disable iff (!up_rstn) credits <= CREDIT_MAX
  );

  // with no credit left and none coming back, no word may take the count below zero
  a_no_send_without_credit: assert property (
    @(posedge up_clk) disable iff (!up_rstn)
      ((credits == '0) && !tx_credit) |=> (credits == '0)
  );

endmodule

// ==== rtl/rtp_pkg.sv ====
/* rtp engine shared definitions
   data widths, configuration and position records, frame state encoding */

package rtp_pkg;

  // **************************************************
  // plain data widths
  // **************************************************

  // stream and register data word
  typedef logic [31:0] rtp_word_t;
  // processor register address
  typedef logic [13:0] rtp_addr_t;
  // line or pixel count and index
  typedef logic [11:0] rtp_dim_t;
  // packet sequence number and frame number
  typedef logic [15:0] rtp_seq_t;

  // header words sent ahead of the pixels of every line
  localparam int HDR_WORDS = 8;
  // ip protocol number for udp, carried in header word 5
  localparam logic [7:0] RTP_PROTO_UDP = 8'h11;

  // **************************************************
  // configuration held by the register map
  // **************************************************

  typedef struct packed {
    logic [31:0] dest_addr_hb;
    logic [15:0] dest_addr_lb;
    logic [31:0] source_addr_hb;
    logic [15:0] source_addr_lb;
    logic [31:0] src_ip_addr;
    logic [31:0] dest_ip_addr;
    logic [7:0]  ip_qos;
    logic [15:0] udp_src_port;
    logic [15:0] udp_dest_port;
    rtp_dim_t    num_lines;
    rtp_dim_t    num_px_p_line;
    // only custom_timestamp has a consumer inside the engine
    logic        custom_timestamp;
    logic        custom_timestamp_96b;
    logic        timestamp_s_eof;
    logic        timestamp_network_pwm_genval;
  } rtp_cfg_t;

  // current position inside the frame, driven by the position counter
  typedef struct packed {
    logic [2:0] hdr_idx;
    rtp_dim_t   px_idx;
    rtp_dim_t   line_idx;
    rtp_seq_t   seq_num;
    rtp_seq_t   frame_num;
  } rtp_pos_t;

  // frame state machine encoding
  typedef enum logic [1:0] {
    st_idle,
    st_header,
    st_payload,
    st_frame_end
  } rtp_state_e;

endpackage

// ==== rtl/rtp_pos_counter.sv ====
/* rtp position counter
   tracks header word, pixel and line indices plus sequence and frame numbers */

`timescale 1ns/1ps

module rtp_pos_counter import rtp_pkg::*; (
  input  logic     up_clk,
  input  logic     up_rstn,
  input  logic     advance,
  input  logic     phase,
  input  logic     frame_clear,
  input  rtp_cfg_t cfg,
  output rtp_pos_t pos
);

  logic hdr_step;
  logic px_step;
  logic pkt_end;

  assign hdr_step = advance && !phase;
  assign px_step  = advance && phase;

  // a packet ends on its last pixel, or on header word 7 for empty lines
  assign pkt_end = (px_step && (pos.px_idx == cfg.num_px_p_line - 12'd1)) ||
                   (hdr_step && (pos.hdr_idx == 3'(HDR_WORDS - 1)) &&
                    (cfg.num_px_p_line == '0));

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      pos <= '0;
    end else begin
      // the header index wraps from 7 back to 0 on its own
      if (hdr_step) begin
        pos.hdr_idx <= pos.hdr_idx + 3'd1;
      end
      if (px_step) begin
        pos.px_idx <= pkt_end ? '0 : pos.px_idx + 12'd1;
      end
      // sequence numbers keep counting across frames
      if (pkt_end) begin
        pos.line_idx <= pos.line_idx + 12'd1;
        pos.seq_num  <= pos.seq_num + 16'd1;
      end
      // frame end rewinds the geometry but leaves the sequence alone
      if (frame_clear) begin
        pos.line_idx  <= '0;
        pos.px_idx    <= '0;
        pos.frame_num <= pos.frame_num + 16'd1;
      end
    end
  end

endmodule

// ==== rtl/rtp_word_builder.sv ====
/* rtp word builder
   forms the current header or pixel word and registers it with its framing flags */

`timescale 1ns/1ps

module rtp_word_builder import rtp_pkg::*; (
  input  logic      up_clk,
  input  logic      up_rstn,
  input  logic      advance,
  input  logic      phase,
  input  rtp_cfg_t  cfg,
  input  rtp_pos_t  pos,
  output logic      tx_valid,
  output rtp_word_t tx_data,
  output logic      tx_sop,
  output logic      tx_eop
);

  rtp_word_t hdr_word;
  rtp_word_t px_word;
  rtp_seq_t  w7_num;
  logic      sop_flag;
  logic      eop_flag;

  // **************************************************
  // word selection
  // **************************************************

  // word 7 carries the frame number instead when custom timestamps are on
  assign w7_num = cfg.custom_timestamp ? pos.frame_num : pos.seq_num;

  always_comb begin
    case (pos.hdr_idx)
      3'd0: hdr_word = cfg.dest_addr_hb;
      3'd1: hdr_word = {cfg.dest_addr_lb, cfg.source_addr_lb};
      3'd2: hdr_word = cfg.source_addr_hb;
      3'd3: hdr_word = cfg.src_ip_addr;
      3'd4: hdr_word = cfg.dest_ip_addr;
      // qos, protocol byte, then the line number in the low half
      3'd5: hdr_word = {cfg.ip_qos, RTP_PROTO_UDP, 4'd0, pos.line_idx};
      3'd6: hdr_word = {cfg.udp_src_port, cfg.udp_dest_port};
      default: hdr_word = {w7_num, 4'd0, cfg.num_px_p_line};
    endcase
  end

  // counting test pattern, line on top and pixel below
  assign px_word = {4'd0, pos.line_idx, 4'd0, pos.px_idx};

  assign sop_flag = !phase && (pos.hdr_idx == 3'd0);
  // eop falls on header word 7 when a line carries no pixels
  assign eop_flag = phase ? (pos.px_idx == cfg.num_px_p_line - 12'd1) :
                    ((pos.hdr_idx == 3'(HDR_WORDS - 1)) && (cfg.num_px_p_line == '0));

  // **************************************************
  // output register
  // **************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      tx_valid <= 1'b0;
      tx_sop   <= 1'b0;
      tx_eop   <= 1'b0;
    end else begin
      tx_valid <= advance;
      tx_sop   <= advance && sop_flag;
      tx_eop   <= advance && eop_flag;
    end
  end

  // the data word only changes when a new word is issued
  always_ff @(posedge up_clk) begin
    if (advance) begin
      tx_data <= phase ? px_word : hdr_word;
    end
  end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the rtp engine testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_rtp_engine -f files.f -o tb_rtp_engine

out=$(./obj_dir/tb_rtp_engine)
echo "$out"

if echo "$out" | grep -q "^TESTBENCH PASSED$"; then
  exit 0
else
  exit 1
fi

// ==== tests/tb_rtp_engine.sv ====
/* rtp engine testbench
   directed register and frame tests against a credit returning sink model */

`timescale 1ns/1ps

module tb_rtp_engine import rtp_pkg::*; ();

  localparam logic [31:0] VERSION = 32'h0001_0203;
  localparam int CREDIT_MAX = 8;
  localparam logic [31:0] SEED = 32'h865d_cee3;
  // the whole test sequence needs roughly 1500 cycles, so this leaves wide margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic      up_clk;
  logic      up_rstn;
  logic      up_wreq;
  rtp_addr_t up_waddr;
  rtp_word_t up_wdata;
  logic      up_wack;
  logic      up_rreq;
  rtp_addr_t up_raddr;
  rtp_word_t up_rdata;
  logic      up_rack;
  logic      tx_valid;
  rtp_word_t tx_data;
  logic      tx_sop;
  logic      tx_eop;
  logic      tx_credit = 1'b0;

  // sink and scoreboard state, each stream entry is {sop, eop, data}
  int          cyc = 0;
  int          sent = 0;
  int          returned = 0;
  int          due_q[$];
  logic [33:0] rx_q[$];
  logic [33:0] exp_q[$];
  bit          hold_credit = 1'b0;
  int          mismatch_cnt = 0;
  int          fail_cnt = 0;
  // register shadow that the header model reads from
  rtp_word_t   sh [0:15];
  logic [15:0] exp_seq = '0;
  logic [15:0] exp_frame = '0;

  rtp_engine #(
    .VERSION(VERSION),
    .CREDIT_MAX(CREDIT_MAX)
  ) u_dut (
    .up_clk(up_clk),
    .up_rstn(up_rstn),
    .up_wreq(up_wreq),
    .up_waddr(up_waddr),
    .up_wdata(up_wdata),
    .up_wack(up_wack),
    .up_rreq(up_rreq),
    .up_raddr(up_raddr),
    .up_rdata(up_rdata),
    .up_rack(up_rack),
    .tx_valid(tx_valid),
    .tx_data(tx_data),
    .tx_sop(tx_sop),
    .tx_eop(tx_eop),
    .tx_credit(tx_credit)
  );

  initial begin
    up_clk = 1'b0;
    forever #2 up_clk = ~up_clk;
  end

  // **************************************************
  // sink model and cycle limit
  // **************************************************

  // every received word is queued and its credit is due 0 to 5 cycles later
  // credits go back one per cycle in arrival order, unless held off
  always @(posedge up_clk) begin
    cyc = cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
      $display("TESTBENCH FAILED");
      $finish;
    end else begin
      if (up_rstn) begin
        if (tx_credit) begin
          returned = returned + 1;
        end
        if (tx_valid) begin
          rx_q.push_back({tx_sop, tx_eop, tx_data});
          sent = sent + 1;
          due_q.push_back(cyc + int'($urandom % 6));
        end
        if (sent - returned > CREDIT_MAX) begin
          $display("more words outstanding at the sink than credits allow at cycle %0d", cyc);
          fail_cnt = fail_cnt + 1;
        end
      end
      #1;
      if (!hold_credit && due_q.size() > 0 && due_q[0] <= cyc) begin
        void'(due_q.pop_front());
        tx_credit = 1'b1;
      end else begin
        tx_credit = 1'b0;
      end
    end
  end

  // **************************************************
  // helpers
  // **************************************************

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      mismatch_cnt = mismatch_cnt + 1;
    end
  endtask

  // width of each register field, from the address map
  function automatic rtp_word_t field_mask(input int addr);
    case (addr)
      2, 4: return 32'h0000_ffff;
      7: return 32'h0000_00ff;
      9, 10: return 32'h0000_0fff;
      11, 12, 13, 14: return 32'h0000_0001;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  // all bus tasks start and end 1 ns after a rising edge
  task automatic write_reg(input int addr, input rtp_word_t data);
    up_wreq  = 1'b1;
    up_waddr = 14'(addr);
    up_wdata = data;
    @(posedge up_clk);
    #1;
    up_wreq = 1'b0;
    if (up_wack !== 1'b1) begin
      $display("write ack missing one cycle after the request to %h", addr);
      fail_cnt = fail_cnt + 1;
    end
    @(posedge up_clk);
    #1;
    if (up_wack !== 1'b0) begin
      $display("write ack to %h stayed high for more than one cycle", addr);
      fail_cnt = fail_cnt + 1;
    end
  endtask

  task automatic read_reg(input int addr, output rtp_word_t data);
    up_rreq  = 1'b1;
    up_raddr = 14'(addr);
    @(posedge up_clk);
    #1;
    up_rreq = 1'b0;
    data = up_rdata;
    if (up_rack !== 1'b1) begin
      $display("read ack missing one cycle after the request to %h", addr);
      fail_cnt = fail_cnt + 1;
    end
    @(posedge up_clk);
    #1;
    if (up_rack !== 1'b0) begin
      $display("read ack from %h stayed high for more than one cycle", addr);
      fail_cnt = fail_cnt + 1;
    end
  endtask

  // reference model, appends one frame to exp_q from the register shadow
  task automatic build_frame(input int lines, input int px);
    rtp_word_t   w;
    logic [15:0] num;
    for (int l = 0; l < lines; l++) begin
      // word 7 shows the frame number in place of the sequence when enabled
      num = sh[11][0] ? exp_frame : exp_seq;
      for (int h = 0; h < 8; h++) begin
        case (h)
          0: w = sh[1];
          1: w = {sh[2][15:0], sh[4][15:0]};
          2: w = sh[3];
          3: w = sh[5];
          4: w = sh[6];
          5: w = {sh[7][7:0], 8'h11, 16'(l)};
          6: w = sh[8];
          default: w = {num, 16'(px)};
        endcase
        exp_q.push_back({h == 0, (h == 7) && (px == 0), w});
      end
      for (int p = 0; p < px; p++) begin
        exp_q.push_back({1'b0, p == px - 1, 16'(l), 16'(p)});
      end
      exp_seq = exp_seq + 16'd1;
    end
    exp_frame = exp_frame + 16'd1;
  endtask

  task automatic set_geometry(input int lines, input int px, input bit custom);
    write_reg(9, 32'(lines));
    write_reg(10, 32'(px));
    write_reg(11, {31'd0, custom});
    sh[9]  = 32'(lines);
    sh[10] = 32'(px);
    sh[11] = {31'd0, custom};
  endtask

  task automatic start_frame();
    rtp_word_t st;
    rx_q.delete();
    write_reg(15, 32'h1);
    read_reg(15, st);
    if (st[0] !== 1'b1) begin
      $display("busy was not set after the frame start");
      fail_cnt = fail_cnt + 1;
    end
  endtask

  // polls the status register, all words must be out once busy reads low
  task automatic wait_idle();
    rtp_word_t st;
    st = 32'h1;
    while (st[0] === 1'b1) begin
      read_reg(15, st);
    end
    expect_equal("words_at_idle", rx_q.size(), exp_q.size());
  endtask

  task automatic compare_stream();
    int n;
    repeat (10) @(posedge up_clk);
    #1;
    expect_equal("word_count", rx_q.size(), exp_q.size());
    n = (rx_q.size() < exp_q.size()) ? rx_q.size() : exp_q.size();
    for (int i = 0; i < n; i++) begin
      expect_equal($sformatf("tx_data[%0d]", i), rx_q[i][31:0], exp_q[i][31:0]);
      expect_equal($sformatf("tx_sop[%0d]", i), {31'd0, rx_q[i][33]}, {31'd0, exp_q[i][33]});
      expect_equal($sformatf("tx_eop[%0d]", i), {31'd0, rx_q[i][32]}, {31'd0, exp_q[i][32]});
    end
    rx_q.delete();
    exp_q.delete();
  endtask

  task automatic run_frame(input int lines, input int px, input bit custom);
    set_geometry(lines, px, custom);
    build_frame(lines, px);
    start_frame();
    wait_idle();
    compare_stream();
  endtask

  // waits until the sink has handed back every credit
  task automatic drain_credits();
    while (sent != returned || due_q.size() != 0) begin
      @(posedge up_clk);
      #1;
    end
  endtask

  // **************************************************
  // directed tests
  // **************************************************

  task automatic register_access();
    rtp_word_t d;
    rtp_word_t v;
    read_reg(0, d);
    expect_equal("up_rdata@0", d, VERSION);
    for (int a = 1; a < 15; a++) begin
      v = $urandom;
      write_reg(a, v);
      sh[a] = v & field_mask(a);
    end
    for (int a = 1; a < 15; a++) begin
      read_reg(a, d);
      expect_equal($sformatf("up_rdata@%h", a), d, sh[a]);
    end
    read_reg(15, d);
    expect_equal("up_rdata@f", d, 32'h0);
    read_reg(16, d);
    expect_equal("up_rdata@10", d, 32'h0);
    read_reg(14'h3fff, d);
    expect_equal("up_rdata@3fff", d, 32'h0);
  endtask

  task automatic frame_content();
    // first frame after reset carries sequence numbers 0 and 1
    run_frame(2, 3, 1'b0);
  endtask

  task automatic back_pressure();
    drain_credits();
    hold_credit = 1'b1;
    set_geometry(3, 10, 1'b0);
    build_frame(3, 10);
    start_frame();
    repeat (40) @(posedge up_clk);
    #1;
    // with no credit coming back the engine stops after a full window
    expect_equal("words_while_held", rx_q.size(), CREDIT_MAX);
    hold_credit = 1'b0;
    wait_idle();
    compare_stream();
  endtask

  task automatic numbering();
    run_frame(2, 3, 1'b0);
    run_frame(2, 3, 1'b1);
  endtask

  task automatic edge_cases();
    run_frame(0, 3, 1'b0);
    // header only packets end on word 7
    run_frame(2, 0, 1'b0);
  endtask

  initial begin
    void'($urandom(SEED));
    up_rstn  = 1'b0;
    up_wreq  = 1'b0;
    up_waddr = '0;
    up_wdata = '0;
    up_rreq  = 1'b0;
    up_raddr = '0;
    for (int a = 0; a < 16; a++) begin
      sh[a] = '0;
    end
    repeat (10) @(posedge up_clk);
    #1;
    up_rstn = 1'b1;

    register_access();
    frame_content();
    back_pressure();
    numbering();
    edge_cases();
    drain_credits();

    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
